// ==== logic/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // word and address sizes
    localparam int addr_w   = 32;
    localparam int data_w   = 32;
    localparam int strb_w   = 4;   // one bit per byte

    // 16 sets, one word per line
    localparam int index_w  = 4;
    localparam int tag_w    = 26;  // addr_w - index_w - 2 offset bits
    localparam int num_sets = 16;

    // main controller states
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_lookup  = 3'd1,  // array output valid, tags compared
        st_rd_req  = 3'd2,  // read miss, waiting for addr_ok
        st_rd_wait = 3'd3,  // read miss, waiting for data_ok
        st_wr_req  = 3'd4,  // write-through to memory
        st_refill  = 3'd5   // one idle cycle after the line write
    } dcache_state_t;

endpackage : dcache_pkg

`default_nettype wire

// ==== logic/dcache_way_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_way_array (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            rd_en,
    input  logic [dcache_pkg::index_w-1:0]  rd_index,
    input  logic                            we,
    input  logic [dcache_pkg::index_w-1:0]  wr_index,
    input  logic [dcache_pkg::tag_w-1:0]    wr_tag,
    input  logic [dcache_pkg::data_w-1:0]   wr_data,
    input  logic [dcache_pkg::strb_w-1:0]   wr_strb,
    output logic [dcache_pkg::tag_w-1:0]    tag,
    output logic                            valid,
    output logic [dcache_pkg::data_w-1:0]   data
);
    import dcache_pkg::*;

    logic [tag_w-1:0]    tag_mem  [num_sets];
    logic [data_w-1:0]   data_mem [num_sets];
    logic [num_sets-1:0] valid_bits;

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_index] <= wr_tag;
            for (int b = 0; b < strb_w; b++) begin
                if (wr_strb[b]) begin
                    data_mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];  // byte merge
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    //////////////////////////////
    // registered read port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_en) begin
            tag  <= tag_mem[rd_index];
            data <= data_mem[rd_index];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (rd_en) begin
            valid <= valid_bits[rd_index];
        end
    end

endmodule : dcache_way_array

`default_nettype wire

// ==== logic/dcache_lru.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_lru (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [dcache_pkg::index_w-1:0]  index,
    input  logic                            use0,
    input  logic                            use1,
    output logic                            victim
);
    import dcache_pkg::*;

    // bit set means way 1 is the least recently used
    logic [num_sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (use0) begin
            lru_bits[index] <= 1'b1;  // way 1 now older
        end else if (use1) begin
            lru_bits[index] <= 1'b0;
        end
    end

    assign victim = lru_bits[index];

endmodule : dcache_lru

`default_nettype wire

// ==== logic/dcache_req_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_req_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            buf_we,
    input  logic                            req_we,
    input  logic [dcache_pkg::addr_w-1:0]   req_addr,
    input  logic [dcache_pkg::data_w-1:0]   req_wdata,
    input  logic [dcache_pkg::strb_w-1:0]   req_wstrb,
    input  logic                            resp_from_mem,
    input  logic [dcache_pkg::data_w-1:0]   mem_rdata,
    input  logic [dcache_pkg::tag_w-1:0]    tag0,
    input  logic                            valid0,
    input  logic [dcache_pkg::data_w-1:0]   data0,
    input  logic [dcache_pkg::tag_w-1:0]    tag1,
    input  logic                            valid1,
    input  logic [dcache_pkg::data_w-1:0]   data1,
    output logic                            buf_we_op,
    output logic [dcache_pkg::index_w-1:0]  buf_index,
    output logic [dcache_pkg::tag_w-1:0]    buf_tag,
    output logic                            hit0,
    output logic                            hit1,
    output logic [dcache_pkg::data_w-1:0]   resp_rdata,
    output logic [dcache_pkg::addr_w-1:0]   mem_addr,
    output logic [dcache_pkg::data_w-1:0]   mem_wdata,
    output logic [dcache_pkg::strb_w-1:0]   mem_wstrb
);
    import dcache_pkg::*;

    logic [data_w-1:0] buf_wdata;
    logic [strb_w-1:0] buf_wstrb;

    // request buffer, loaded at acceptance
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_we_op <= 1'b0;
        end else if (buf_we) begin
            buf_we_op <= req_we;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            buf_tag   <= req_addr[addr_w-1 -: tag_w];
            buf_index <= req_addr[index_w+1:2];
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // tag compare against the registered array outputs
    assign hit0 = valid0 && (tag0 == buf_tag);
    assign hit1 = valid1 && (tag1 == buf_tag);

    assign resp_rdata = resp_from_mem ? mem_rdata :  // forwarded refill word
                        hit1          ? data1     : data0;

    //////////////////////////////
    // memory request fields
    //////////////////////////////

    assign mem_addr  = {buf_tag, buf_index, 2'b00};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_we_op ? buf_wstrb : {strb_w{1'b1}};  // reads fetch whole word

endmodule : dcache_req_stage

`default_nettype wire

// ==== logic/dcache_ctrl_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl_fsm (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  logic        hit0,
    input  logic        hit1,
    input  logic        buf_we_op,
    input  logic        victim,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic        req_ready,
    output logic        buf_we,
    output logic        resp_valid,
    output logic        resp_from_mem,
    output logic [1:0]  way_we,
    output logic        refill_sel,
    output logic        use0,
    output logic        use1,
    output logic        mem_req,
    output logic        mem_wr
);
    import dcache_pkg::*;

    dcache_state_t state;
    dcache_state_t next_state;
    logic          hit;

    assign hit = hit0 | hit1;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                if (buf_we_op) begin
                    next_state = st_wr_req;  // write-through, hit or not
                end else if (!hit) begin
                    // addr_ok may already come in this cycle
                    next_state = mem_addr_ok ? st_rd_wait : st_rd_req;
                end else if (req_valid) begin
                    next_state = st_lookup;  // back to back hit
                end else begin
                    next_state = st_idle;
                end
            end
            st_rd_req: begin
                if (mem_addr_ok) begin
                    next_state = st_rd_wait;
                end
            end
            st_rd_wait: begin
                if (mem_data_ok) begin
                    next_state = st_refill;
                end
            end
            st_wr_req: begin
                if (mem_addr_ok) begin
                    next_state = req_valid ? st_lookup : st_idle;
                end
            end
            st_refill: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    //////////////////////////////
    // output decode
    //////////////////////////////

    always_comb begin
        req_ready     = 1'b0;
        buf_we        = 1'b0;
        resp_valid    = 1'b0;
        resp_from_mem = 1'b0;
        way_we        = 2'b00;
        refill_sel    = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
                buf_we    = (next_state == st_lookup);
            end
            st_lookup: begin
                case (next_state)
                    st_lookup, st_idle: begin  // read hit
                        req_ready  = 1'b1;
                        buf_we     = (next_state == st_lookup);
                        resp_valid = 1'b1;
                        use0       = hit0;
                        use1       = hit1 & ~hit0;
                    end
                    st_rd_req, st_rd_wait: begin  // read miss
                        mem_req = 1'b1;
                    end
                    st_wr_req: begin
                        // store hit updates the line, a miss leaves it alone
                        if (hit0) begin
                            way_we[0] = 1'b1;
                            use0      = 1'b1;
                        end else if (hit1) begin
                            way_we[1] = 1'b1;
                            use1      = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            st_rd_req: begin
                mem_req = 1'b1;  // held until addr_ok
            end
            st_rd_wait: begin
                if (next_state == st_refill) begin
                    resp_valid    = 1'b1;
                    resp_from_mem = 1'b1;
                    refill_sel    = 1'b1;
                    way_we        = victim ? 2'b10 : 2'b01;
                    use0          = ~victim;
                    use1          = victim;
                end
            end
            st_wr_req: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    req_ready = 1'b1;
                    buf_we    = (next_state == st_lookup);
                end
            end
            st_refill: begin
                // ready stays low, array write settles first
            end
            default: begin
            end
        endcase
    end

endmodule : dcache_ctrl_fsm

`default_nettype wire

// ==== logic/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                            clk,
    input  logic                            rstn,
    // processor port
    input  logic                            req_valid,
    input  logic                            req_we,
    input  logic [dcache_pkg::addr_w-1:0]   req_addr,
    input  logic [dcache_pkg::data_w-1:0]   req_wdata,
    input  logic [dcache_pkg::strb_w-1:0]   req_wstrb,
    output logic                            req_ready,
    output logic                            resp_valid,
    output logic [dcache_pkg::data_w-1:0]   resp_rdata,
    // memory port
    output logic                            mem_req,
    output logic                            mem_wr,
    output logic [dcache_pkg::addr_w-1:0]   mem_addr,
    output logic [dcache_pkg::data_w-1:0]   mem_wdata,
    output logic [dcache_pkg::strb_w-1:0]   mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [dcache_pkg::data_w-1:0]   mem_rdata
);
    import dcache_pkg::*;

    logic               buf_we;
    logic               buf_we_op;
    logic [index_w-1:0] buf_index;
    logic [tag_w-1:0]   buf_tag;
    logic               hit0;
    logic               hit1;
    logic               victim;
    logic               use0;
    logic               use1;
    logic [1:0]         way_we;
    logic               refill_sel;
    logic               resp_from_mem;
    logic [tag_w-1:0]   tag0;
    logic [tag_w-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    logic [data_w-1:0]  data0;
    logic [data_w-1:0]  data1;
    logic [data_w-1:0]  fill_data;
    logic [strb_w-1:0]  fill_strb;

    // line write source, refill or buffered store
    assign fill_data = refill_sel ? mem_rdata : mem_wdata;
    assign fill_strb = refill_sel ? {strb_w{1'b1}} : mem_wstrb;

    dcache_ctrl_fsm u_fsm (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .hit0(hit0), .hit1(hit1),
        .buf_we_op(buf_we_op), .victim(victim), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .req_ready(req_ready), .buf_we(buf_we),
        .resp_valid(resp_valid), .resp_from_mem(resp_from_mem), .way_we(way_we),
        .refill_sel(refill_sel), .use0(use0), .use1(use1), .mem_req(mem_req), .mem_wr(mem_wr)
    );

    dcache_req_stage u_req (
        .clk(clk), .rstn(rstn), .buf_we(buf_we), .req_we(req_we), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb), .resp_from_mem(resp_from_mem),
        .mem_rdata(mem_rdata), .tag0(tag0), .valid0(valid0), .data0(data0),
        .tag1(tag1), .valid1(valid1), .data1(data1), .buf_we_op(buf_we_op),
        .buf_index(buf_index), .buf_tag(buf_tag), .hit0(hit0), .hit1(hit1),
        .resp_rdata(resp_rdata), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb)
    );

    dcache_lru u_lru (
        .clk(clk), .rstn(rstn), .index(buf_index), .use0(use0), .use1(use1), .victim(victim)
    );

    // both ways start their read with the accepted index
    dcache_way_array way0 (
        .clk(clk), .rstn(rstn), .rd_en(buf_we), .rd_index(req_addr[index_w+1:2]),
        .we(way_we[0]), .wr_index(buf_index), .wr_tag(buf_tag), .wr_data(fill_data),
        .wr_strb(fill_strb), .tag(tag0), .valid(valid0), .data(data0)
    );

    dcache_way_array way1 (
        .clk(clk), .rstn(rstn), .rd_en(buf_we), .rd_index(req_addr[index_w+1:2]),
        .we(way_we[1]), .wr_index(buf_index), .wr_tag(buf_tag), .wr_data(fill_data),
        .wr_strb(fill_strb), .tag(tag1), .valid(valid1), .data(data1)
    );

endmodule : dcache_top

`default_nettype wire

// ==== tb/dcache_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic        resp_valid,
    input  logic [31:0] resp_rdata,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    input  logic        mem_addr_ok,
    output int          mismatch_count,
    output int          other_count,
    output int          done_count
);
    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] rdata;
        logic        miss;
    } access_t;

    access_t exp_q [$];
    access_t cur;
    logic    cur_valid;
    int      rd_count;
    int      lat;

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        done_count     = 0;
        cur_valid      = 1'b0;
        rd_count       = 0;
        lat            = 0;
    end

    // called by the driver before the request goes out
    task automatic expect_access(input logic op, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] strb,
                                 input logic [31:0] rdata, input logic miss);
        access_t a;
        a = '{op, addr, wdata, strb, rdata, miss};
        exp_q.push_back(a);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatch_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        other_count++;
    endtask

    //////////////////////////////
    // compare at each edge
    //////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            if (!req_ready || mem_req || resp_valid) begin
                report_failure("outputs not in their reset state");
            end
        end else begin
            if (cur_valid) lat++;
            if (mem_req && mem_addr_ok) begin
                if (!cur_valid) begin
                    report_failure("memory request with no access in flight");
                end else if (mem_wr != cur.op) begin
                    report_failure("memory request of the wrong direction");
                end else if (mem_wr) begin
                    if (mem_addr != {cur.addr[31:2], 2'b00})
                        report_mismatch("mem_addr", mem_addr, {cur.addr[31:2], 2'b00});
                    if (mem_wdata != cur.wdata)
                        report_mismatch("mem_wdata", mem_wdata, cur.wdata);
                    if (mem_wstrb != cur.strb)
                        report_mismatch("mem_wstrb", {28'd0, mem_wstrb}, {28'd0, cur.strb});
                    cur_valid = 1'b0;  // store is done at its write
                    done_count++;
                end else begin
                    rd_count++;
                    if (mem_addr != {cur.addr[31:2], 2'b00})
                        report_mismatch("mem_addr", mem_addr, {cur.addr[31:2], 2'b00});
                    if (mem_wstrb != 4'hf)  // reads fetch the whole word
                        report_mismatch("mem_wstrb", {28'd0, mem_wstrb}, 32'h0000_000f);
                end
            end
            if (resp_valid) begin
                if (!cur_valid || cur.op) begin
                    report_failure("response without a read in flight");
                end else begin
                    if (resp_rdata != cur.rdata)
                        report_mismatch("resp_rdata", resp_rdata, cur.rdata);
                    if ((rd_count > 0) != cur.miss)
                        report_mismatch("miss", {31'd0, rd_count > 0}, {31'd0, cur.miss});
                    if (rd_count > 1)
                        report_failure("more than one memory read for one miss");
                    if (!cur.miss && lat != 1)
                        report_failure("read hit response not one cycle after acceptance");
                    cur_valid = 1'b0;
                    done_count++;
                end
            end
            // a new request may share the edge with a completion so it goes last
            if (req_valid && req_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("request accepted with no expected values");
                end else begin
                    if (cur_valid) report_failure("request accepted during another access");
                    cur       = exp_q.pop_front();
                    cur_valid = 1'b1;
                    rd_count  = 0;
                    lat       = 0;
                end
            end
        end
    end

endmodule : dcache_checker

`default_nettype wire

// ==== tb/dcache_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_asserts (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            req_ready,
    input  logic                            resp_valid,
    input  logic                            mem_req,
    input  logic                            mem_wr,
    input  logic [dcache_pkg::addr_w-1:0]   mem_addr,
    input  logic [dcache_pkg::data_w-1:0]   mem_wdata,
    input  logic [dcache_pkg::strb_w-1:0]   mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok
);
    int fail_count = 0;

    // request held with stable fields until addr_ok
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_wstrb))
        else begin
            fail_count++;
            $error("mem_req dropped or its fields changed before mem_addr_ok");
        end

    a_resp_no_req: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && mem_req))
        else begin
            fail_count++;
            $error("resp_valid high together with mem_req");
        end

    a_refill_gap: assert property (@(posedge clk) disable iff (!rstn)
        mem_data_ok |=> !req_ready)
        else begin
            fail_count++;
            $error("req_ready high in the cycle after mem_data_ok");
        end

endmodule : dcache_asserts

bind dcache_top dcache_asserts u_asserts (
    .clk(clk), .rstn(rstn), .req_ready(req_ready), .resp_valid(resp_valid),
    .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
);

`default_nettype wire

// ==== tb/dcache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
    localparam int          mem_depth   = 1024;           // words
    localparam logic [31:0] fill_offset = 32'h5a00_0000;  // stated in the tests file
    localparam int          max_lat     = 3;
    localparam int          seed        = 27;

    logic clk = 1'b0;
    logic rstn;
    logic req_valid, req_we, req_ready, resp_valid;
    logic [31:0] req_addr, req_wdata, resp_rdata;
    logic [3:0]  req_wstrb;
    logic mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic [3:0]  mem_wstrb;

    logic [31:0] mem_array [mem_depth];
    logic        t_op [$];
    logic [31:0] t_addr [$];
    logic [31:0] t_wdata [$];
    logic [3:0]  t_strb [$];
    logic [31:0] t_rdata [$];
    logic        t_miss [$];
    int n_tests = 0;
    int limit = 0;
    int cycle_count = 0;
    int addr_wait = -1;
    int data_wait = 0;
    logic rd_pending = 1'b0;
    logic [31:0] rd_addr;
    logic accepted = 1'b0;
    logic hs_seen = 1'b0;
    logic hs_wr;
    logic [31:0] hs_addr, hs_wdata;
    logic [3:0]  hs_strb;
    int mismatch_count, other_count, done_count;

    always #4 clk = ~clk;

    dcache_top dut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_we(req_we),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .req_ready(req_ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .mem_rdata(mem_rdata)
    );

    dcache_checker chk (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata), .mem_req(mem_req),
        .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok),
        .mismatch_count(mismatch_count), .other_count(other_count),
        .done_count(done_count)
    );

    //////////////////////////////
    // memory model
    //////////////////////////////

    always @(posedge clk) begin
        accepted <= req_valid && req_ready;
        hs_seen  <= rstn && mem_req && mem_addr_ok;
        hs_wr    <= mem_wr;
        hs_addr  <= mem_addr;
        hs_wdata <= mem_wdata;
        hs_strb  <= mem_wstrb;
    end

    always @(negedge clk) begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        if (!rstn) begin
            addr_wait  = -1;
            rd_pending = 1'b0;
        end else begin
            if (hs_seen) begin
                if (hs_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (hs_strb[b]) mem_array[hs_addr[11:2]][8*b +: 8] = hs_wdata[8*b +: 8];
                    end
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = hs_addr;
                    data_wait  = $urandom_range(max_lat, 0);
                end
            end
            if (rd_pending) begin
                if (data_wait == 0) begin
                    mem_data_ok = 1'b1;
                    mem_rdata   = mem_array[rd_addr[11:2]];
                    rd_pending  = 1'b0;
                end else begin
                    data_wait--;
                end
            end
            if (mem_req) begin
                if (addr_wait < 0) addr_wait = $urandom_range(max_lat, 0);
                if (addr_wait == 0) begin
                    mem_addr_ok = 1'b1;
                    addr_wait   = -1;
                end else begin
                    addr_wait--;
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (limit != 0 && cycle_count >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d accesses done",
                     cycle_count, done_count, n_tests);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_tests(output logic ok);
        int fd;
        int n;
        string line;
        logic [31:0] f_op, f_addr, f_wdata, f_strb, f_rdata, f_miss;
        ok = 1'b0;
        fd = $fopen("tb/dcache_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f_op, f_addr, f_wdata, f_strb, f_rdata, f_miss);
                    if (n == 6) begin
                        t_op.push_back(f_op[0]);
                        t_addr.push_back(f_addr);
                        t_wdata.push_back(f_wdata);
                        t_strb.push_back(f_strb[3:0]);
                        t_rdata.push_back(f_rdata);
                        t_miss.push_back(f_miss[0]);
                    end else begin
                        $display("error: malformed line in tests file: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = t_op.size();
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        logic ok;
        void'($urandom(seed));
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        for (int i = 0; i < mem_depth; i++) begin
            mem_array[i] = 32'(i * 4) + fill_offset;  // word holds its address plus offset
        end
        load_tests(ok);
        if (!ok || n_tests == 0) begin
            $display("error: tests file missing, empty or malformed");
            $display("*** FAILED ***");
            $finish;
        end else begin
            limit = 40 * n_tests + 100;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rstn = 1'b1;
            @(negedge clk);
            for (int i = 0; i < n_tests; i++) begin
                req_valid = 1'b1;
                req_we    = t_op[i];
                req_addr  = t_addr[i];
                req_wdata = t_wdata[i];
                req_wstrb = t_strb[i];
                chk.expect_access(t_op[i], t_addr[i], t_wdata[i], t_strb[i],
                                  t_rdata[i], t_miss[i]);
                do begin
                    @(negedge clk);
                end while (!accepted);
            end
            req_valid = 1'b0;
            while (done_count < n_tests) @(negedge clk);
            repeat (3) @(negedge clk);  // let the last assertions see the tail
            $display("done %0d of %0d, mismatches %0d, other errors %0d, assertion errors %0d",
                     done_count, n_tests, mismatch_count, other_count,
                     dut.u_asserts.fail_count);
            if (mismatch_count + other_count + dut.u_asserts.fail_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule : dcache_tb

`default_nettype wire

// ==== vlog.f ====
logic/dcache_pkg.sv
logic/dcache_way_array.sv
logic/dcache_lru.sv
logic/dcache_req_stage.sv
logic/dcache_ctrl_fsm.sv
logic/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_asserts.sv
tb/dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir

# the simulator status is ignored, the log decides
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/dcache_tests.txt ====
# op(0 read, 1 write) addr wdata strb exp_rdata exp_miss, all hex, unused fields 0
# memory word at address a starts as a + 5a000000, exp_miss is checked on reads only
0 00000010 00000000 0 5a000010 1
0 00000010 00000000 0 5a000010 0
0 00000014 00000000 0 5a000014 1
1 00000010 112233ff 1 00000000 0
0 00000010 00000000 0 5a0000ff 0
1 00000024 a1b2c3d4 c 00000000 1
0 00000024 00000000 0 a1b20024 1
0 00000024 00000000 0 a1b20024 0
# set 3, three tags
0 0000000c 00000000 0 5a00000c 1
0 0000004c 00000000 0 5a00004c 1
0 0000000c 00000000 0 5a00000c 0
0 0000008c 00000000 0 5a00008c 1
0 0000000c 00000000 0 5a00000c 0
0 0000004c 00000000 0 5a00004c 1
0 0000000c 00000000 0 5a00000c 0
0 0000008c 00000000 0 5a00008c 1
1 0000008c 00ee0000 4 00000000 0
0 0000008c 00000000 0 5aee008c 0
0 0000000c 00000000 0 5a00000c 0
0 00000fc0 00000000 0 5a000fc0 1
0 00000fc0 00000000 0 5a000fc0 0
1 00000fc0 01020304 f 00000000 0
0 00000fc0 00000000 0 01020304 0
0 0000004c 00000000 0 5a00004c 1
